//--- source/aluSettings.svh
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// Datapath and register file sizing
`define DATA_WIDTH 16
`define REG_COUNT 16
`define REG_ADDR_WIDTH 4   // Index into REG_COUNT registers

// Instruction field widths
`define OPCODE_WIDTH 4
`define IMM_WIDTH 4        // Overlays rt
`define BYTE_WIDTH 8       // Overlays rs and rt

`endif

//--- source/isaPkg.sv
`default_nettype none
`include "aluSettings.svh"

package isaPkg;

    // Named ops, C to F fall through as no-ops
    typedef enum logic [`OPCODE_WIDTH-1:0] {
        opAdd    = 4'h0,
        opSub    = 4'h1,
        opXor    = 4'h2,
        opRed    = 4'h3,
        opSll    = 4'h4,
        opSra    = 4'h5,
        opRor    = 4'h6,
        opPaddsb = 4'h7,
        opLw     = 4'h8,
        opSw     = 4'h9,
        opLlb    = 4'hA,
        opLhb    = 4'hB
    } opcodeT;

    typedef logic [`REG_ADDR_WIDTH-1:0] regAddrT;

    // Word layout from bit 15 down
    typedef struct packed {
        opcodeT  opcode;   // [15:12]
        regAddrT rd;       // [11:8]
        regAddrT rs;       // [7:4]
        regAddrT rt;       // [3:0]
    } instrT;

    function automatic logic [`IMM_WIDTH-1:0] imm4(input instrT word);
        return word.rt;
    endfunction

    function automatic logic [`BYTE_WIDTH-1:0] imm8(input instrT word);
        return {word.rs, word.rt};
    endfunction

endpackage

`default_nettype wire

//--- source/execPkg.sv
`default_nettype none
`include "aluSettings.svh"

package execPkg;

    // Condition codes
    typedef struct packed {
        logic zero;
        logic overflow;
        logic negative;
    } flagsT;

    // Decode to execute payload
    typedef struct packed {
        isaPkg::opcodeT          opcode;
        logic [`DATA_WIDTH-1:0]  operandA;
        logic [`DATA_WIDTH-1:0]  operandB;
        isaPkg::regAddrT         dest;
        logic                    writesReg;   // Already filtered by opcode
    } execBundleT;

    // Execute output record
    typedef struct packed {
        logic [`DATA_WIDTH-1:0]  result;
        isaPkg::regAddrT         dest;
        logic                    writesReg;
        logic                    isAddress;   // LW or SW effective address
    } resultRecT;

endpackage

`default_nettype wire

//--- source/execBus.sv
`timescale 1ns/1ps
`default_nettype none

// One registered execute bundle per cycle
interface execBus;

    logic                valid;    // One cycle per instruction
    execPkg::execBundleT bundle;

    // Pipeline register side
    modport source (
        output valid,
        output bundle
    );

    // Execute stage side
    modport sink (
        input valid,
        input bundle
    );

endinterface

`default_nettype wire

//--- source/pipeStage.sv
`timescale 1ns/1ps
`default_nettype none

module pipeStage #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    inValid,
    input  payloadT inData,
    output logic    outValid,
    output payloadT outData
);

    // Valid bit
    always_ff @(posedge clk) begin
        if (rst)
            outValid <= 1'b0;
        else
            outValid <= inValid;
    end

    always_ff @(posedge clk) begin
        if (inValid)
            outData <= inData;   // Holds between instructions
    end

endmodule

`default_nettype wire

//--- source/aluCore.sv
`timescale 1ns/1ps
`default_nettype none
`include "aluSettings.svh"

module aluCore (
    input  isaPkg::opcodeT         opcode,
    input  logic [`DATA_WIDTH-1:0] operandA,
    input  logic [`DATA_WIDTH-1:0] operandB,
    output logic [`DATA_WIDTH-1:0] result,
    output execPkg::flagsT         flags,
    output logic                   flagWrite
);

    localparam int W = `DATA_WIDTH;
    localparam int B = `BYTE_WIDTH;
    localparam logic [W-1:0] maxPos = {1'b0, {(W-1){1'b1}}};
    localparam logic [W-1:0] minNeg = {1'b1, {(W-1){1'b0}}};

    logic         subSel, isAddSub;
    logic [W-1:0] addB, addSum, addSat;
    logic         addOvfl;
    logic [B:0]   redHigh, redLow;    // 9-bit signed byte sums
    logic [B+1:0] redTotal;           // 10-bit signed
    logic [W-1:0] redOut, paddOut, shiftOut, addrOut;
    logic [2*W-1:0] rotWide;
    logic [3:0]   shiftAmt;

    // Saturating add/sub, SUB as A + ~B + 1
    assign subSel  = (opcode == isaPkg::opSub);
    assign addB    = subSel ? ~operandB : operandB;
    assign addSum  = operandA + addB + subSel;
    assign addOvfl = (operandA[W-1] == addB[W-1]) && (addSum[W-1] != operandA[W-1]);
    assign addSat  = addOvfl ? (operandA[W-1] ? minNeg : maxPos) : addSum;

    // Byte reduction
    assign redHigh  = {operandA[W-1], operandA[W-1:B]} + {operandB[W-1], operandB[W-1:B]};
    assign redLow   = {operandA[B-1], operandA[B-1:0]} + {operandB[B-1], operandB[B-1:0]};
    assign redTotal = {redHigh[B], redHigh} + {redLow[B], redLow};
    assign redOut   = {{(W-B-2){redTotal[B+1]}}, redTotal};

    // Four nibble lanes, each clamps to 7 or 8
    always_comb begin
        logic [3:0] nibA, nibB, nibSum;
        for (int i = 0; i < W/4; i++) begin
            nibA   = operandA[4*i +: 4];
            nibB   = operandB[4*i +: 4];
            nibSum = nibA + nibB;
            if ((nibA[3] == nibB[3]) && (nibSum[3] != nibA[3]))
                paddOut[4*i +: 4] = nibA[3] ? 4'h8 : 4'h7;
            else
                paddOut[4*i +: 4] = nibSum;
        end
    end

    // Shifter, low opcode bits pick the mode
    assign shiftAmt = operandB[3:0];
    assign rotWide  = {operandA, operandA} >> shiftAmt;
    always_comb begin
        case (opcode)
            isaPkg::opSll: shiftOut = operandA << shiftAmt;
            isaPkg::opSra: shiftOut = $signed(operandA) >>> shiftAmt;
            default:       shiftOut = rotWide[W-1:0];   // ROR
        endcase
    end

    // LW/SW effective address, wraps
    assign addrOut = (operandA & ~{{(W-1){1'b0}}, 1'b1}) + (operandB << 1);

    // Result select
    always_comb begin
        case (opcode)
            isaPkg::opAdd, isaPkg::opSub:                result = addSat;
            isaPkg::opXor:                               result = operandA ^ operandB;
            isaPkg::opRed:                               result = redOut;
            isaPkg::opSll, isaPkg::opSra, isaPkg::opRor: result = shiftOut;
            isaPkg::opPaddsb:                            result = paddOut;
            isaPkg::opLw, isaPkg::opSw:                  result = addrOut;
            isaPkg::opLlb: result = {operandA[W-1:B], operandB[B-1:0]};   // Keep high byte
            isaPkg::opLhb: result = {operandB[B-1:0], operandA[B-1:0]};   // Keep low byte
            default:                                     result = '0;
        endcase
    end

    // Flags
    assign isAddSub       = (opcode == isaPkg::opAdd) || subSel;
    assign flags.zero     = (result == '0);
    assign flags.overflow = isAddSub & addOvfl;
    assign flags.negative = isAddSub & result[W-1];

    always_comb begin
        case (opcode)
            isaPkg::opAdd, isaPkg::opSub, isaPkg::opXor,
            isaPkg::opSll, isaPkg::opSra, isaPkg::opRor: flagWrite = 1'b1;
            default:                                     flagWrite = 1'b0;   // RED, PADDSB, memory, no-ops
        endcase
    end

endmodule

`default_nettype wire

//--- source/operandDecode.sv
`timescale 1ns/1ps
`default_nettype none
`include "aluSettings.svh"

module operandDecode (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instrValid,
    input  isaPkg::instrT          instr,
    input  logic                   wbEnable,
    input  isaPkg::regAddrT        wbDest,
    input  logic [`DATA_WIDTH-1:0] wbData,
    output logic                   bundleValid,
    output execPkg::execBundleT    bundle
);

    localparam int W = `DATA_WIDTH;

    logic [W-1:0] regFile [`REG_COUNT];
    logic [W-1:0] rsData, rtData, rdData;
    logic [`IMM_WIDTH-1:0]  immShort;
    logic [`BYTE_WIDTH-1:0] immByte;

    // r0 reads zero, a same-cycle writeback wins over the stored copy
    function automatic logic [W-1:0] bypassRead(
        input isaPkg::regAddrT addr,
        input logic [W-1:0]    stored,
        input logic            wrEn,
        input isaPkg::regAddrT wrAddr,
        input logic [W-1:0]    wrData
    );
        if (addr == '0)
            return '0;
        if (wrEn && (wrAddr == addr))
            return wrData;   // Write-through
        return stored;
    endfunction

    // Register file write port
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++)
                regFile[i] <= '0;
        end else if (wbEnable && (wbDest != '0)) begin   // r0 stays zero
            regFile[wbDest] <= wbData;
        end
    end

    // Three read ports
    assign rsData = bypassRead(instr.rs, regFile[instr.rs], wbEnable, wbDest, wbData);
    assign rtData = bypassRead(instr.rt, regFile[instr.rt], wbEnable, wbDest, wbData);
    assign rdData = bypassRead(instr.rd, regFile[instr.rd], wbEnable, wbDest, wbData);

    assign immShort = isaPkg::imm4(instr);
    assign immByte  = isaPkg::imm8(instr);

    assign bundleValid = instrValid;

    // Operand and writeback selection per opcode
    always_comb begin
        bundle.opcode    = instr.opcode;
        bundle.dest      = instr.rd;
        bundle.operandA  = rsData;   // Common case
        bundle.operandB  = rtData;
        bundle.writesReg = 1'b0;
        case (instr.opcode)
            isaPkg::opAdd, isaPkg::opSub, isaPkg::opXor,
            isaPkg::opRed, isaPkg::opPaddsb: begin
                bundle.writesReg = 1'b1;
            end
            isaPkg::opSll, isaPkg::opSra, isaPkg::opRor: begin
                bundle.operandB  = {{(W-`IMM_WIDTH){1'b0}}, immShort};   // Shift amount
                bundle.writesReg = 1'b1;
            end
            isaPkg::opLw, isaPkg::opSw: begin
                bundle.operandB = {{(W-`IMM_WIDTH){immShort[`IMM_WIDTH-1]}}, immShort};
            end
            isaPkg::opLlb, isaPkg::opLhb: begin
                bundle.operandA  = rdData;   // Byte merge into rd
                bundle.operandB  = {{(W-`BYTE_WIDTH){1'b0}}, immByte};
                bundle.writesReg = 1'b1;
            end
            default: begin   // C to F
                bundle.operandA = '0;
                bundle.operandB = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/executeUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "aluSettings.svh"

module executeUnit (
    input  logic                   clk,
    input  logic                   rst,
    execBus.sink                   exec,
    output logic                   wbEnable,
    output isaPkg::regAddrT        wbDest,
    output logic [`DATA_WIDTH-1:0] wbData,
    output logic                   resultValid,
    output logic [`DATA_WIDTH-1:0] result,
    output isaPkg::regAddrT        resultDest,
    output logic                   isAddress,
    output execPkg::flagsT         flags
);

    logic [`DATA_WIDTH-1:0] aluResult;
    execPkg::flagsT         aluFlags;
    logic                   aluFlagWrite;
    execPkg::resultRecT     recIn, recOut;

    aluCore aluCore_inst (
        .opcode    (exec.bundle.opcode),
        .operandA  (exec.bundle.operandA),
        .operandB  (exec.bundle.operandB),
        .result    (aluResult),
        .flags     (aluFlags),
        .flagWrite (aluFlagWrite)
    );

    // Same-cycle writeback into decode
    assign wbEnable = exec.valid & exec.bundle.writesReg;
    assign wbDest   = exec.bundle.dest;
    assign wbData   = aluResult;

    // Flag register
    always_ff @(posedge clk) begin
        if (rst)
            flags <= '0;
        else if (exec.valid && aluFlagWrite)
            flags <= aluFlags;
    end

    assign recIn.result    = aluResult;
    assign recIn.dest      = exec.bundle.dest;
    assign recIn.writesReg = exec.bundle.writesReg;
    assign recIn.isAddress = (exec.bundle.opcode == isaPkg::opLw) ||
                             (exec.bundle.opcode == isaPkg::opSw);

    pipeStage #(.payloadT(execPkg::resultRecT)) resultStage_inst (
        .clk      (clk),
        .rst      (rst),
        .inValid  (exec.valid),
        .inData   (recIn),
        .outValid (resultValid),
        .outData  (recOut)
    );

    assign result     = recOut.result;
    assign resultDest = recOut.dest;
    assign isAddress  = recOut.isAddress;

endmodule

`default_nettype wire

//--- source/aluSubsystem.sv
`timescale 1ns/1ps
`default_nettype none
`include "aluSettings.svh"

module aluSubsystem (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instrValid,
    input  isaPkg::instrT          instr,
    output logic                   resultValid,
    output logic [`DATA_WIDTH-1:0] result,
    output isaPkg::regAddrT        resultDest,
    output logic                   isAddress,
    output execPkg::flagsT         flags
);

    logic                   decValid;
    execPkg::execBundleT    decBundle;
    logic                   wbEnable;
    isaPkg::regAddrT        wbDest;
    logic [`DATA_WIDTH-1:0] wbData;

    execBus execLink ();   // Decode register to execute

    operandDecode operandDecode_inst (
        .clk         (clk),
        .rst         (rst),
        .instrValid  (instrValid),
        .instr       (instr),
        .wbEnable    (wbEnable),
        .wbDest      (wbDest),
        .wbData      (wbData),
        .bundleValid (decValid),
        .bundle      (decBundle)
    );

    // Cycle N to N+1
    pipeStage #(.payloadT(execPkg::execBundleT)) execStage_inst (
        .clk      (clk),
        .rst      (rst),
        .inValid  (decValid),
        .inData   (decBundle),
        .outValid (execLink.valid),
        .outData  (execLink.bundle)
    );

    // Result lands in N+2
    executeUnit executeUnit_inst (
        .clk         (clk),
        .rst         (rst),
        .exec        (execLink.sink),
        .wbEnable    (wbEnable),
        .wbDest      (wbDest),
        .wbData      (wbData),
        .resultValid (resultValid),
        .result      (result),
        .resultDest  (resultDest),
        .isAddress   (isAddress),
        .flags       (flags)
    );

endmodule

`default_nettype wire

//--- testbench/aluRefModel.svh
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

logic [`DATA_WIDTH-1:0] regMirror [`REG_COUNT];   // Architectural registers
logic [2:0]             flagMirror;               // {zero, overflow, negative}

task automatic modelReset();
    for (int i = 0; i < `REG_COUNT; i++)
        regMirror[i] = '0;
    flagMirror = '0;
endtask

// Limit a signed value to the range of a two's complement field
function automatic int clampSigned(input int value, input int bits);
    int hi;
    int lo;
    hi = (1 << (bits - 1)) - 1;
    lo = -(1 << (bits - 1));
    if (value > hi)
        return hi;
    if (value < lo)
        return lo;
    return value;
endfunction

// Signed reading of a bit field
function automatic int fieldSigned(input logic [15:0] word, input int lsb, input int bits);
    int raw;
    raw = (int'(word) >> lsb) & ((1 << bits) - 1);
    if (raw >= (1 << (bits - 1)))
        raw = raw - (1 << bits);
    return raw;
endfunction

// Issue one instruction against the mirror, in program order
task automatic modelIssue(input logic [15:0] word, output logic [15:0] expResult,
                          output logic expIsAddr);
    logic [3:0]  op;
    logic [3:0]  rd;
    logic [3:0]  rs;
    logic [3:0]  rt;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] res;
    logic        ovfl;
    logic        setsFlags;
    logic        writes;
    int          sum;
    op = word[15:12];
    rd = word[11:8];
    rs = word[7:4];
    rt = word[3:0];
    a = regMirror[rs];   // r0 mirror stays zero
    b = regMirror[rt];
    res = '0;
    ovfl = 1'b0;
    setsFlags = 1'b0;
    writes = 1'b1;
    expIsAddr = 1'b0;
    case (op)
        4'h0, 4'h1: begin
            if (op == 4'h0)
                sum = fieldSigned(a, 0, 16) + fieldSigned(b, 0, 16);
            else
                sum = fieldSigned(a, 0, 16) - fieldSigned(b, 0, 16);
            res = 16'(clampSigned(sum, 16));
            ovfl = (clampSigned(sum, 16) != sum);   // Clamped means overflow
            setsFlags = 1'b1;
        end
        4'h2: begin
            res = a ^ b;
            setsFlags = 1'b1;
        end
        4'h3: begin
            sum = fieldSigned(a, 8, 8) + fieldSigned(b, 8, 8)
                + fieldSigned(a, 0, 8) + fieldSigned(b, 0, 8);
            res = 16'(sum);   // Fits 10 bits signed
        end
        4'h4: begin
            res = a;
            for (int k = 0; k < int'(rt); k++)
                res = {res[14:0], 1'b0};   // Zeros shift in
            setsFlags = 1'b1;
        end
        4'h5: begin
            res = a;
            for (int k = 0; k < int'(rt); k++)
                res = {res[15], res[15:1]};   // Sign bit fills
            setsFlags = 1'b1;
        end
        4'h6: begin
            res = a;
            for (int k = 0; k < int'(rt); k++)
                res = {res[0], res[15:1]};   // One bit at a time
            setsFlags = 1'b1;
        end
        4'h7: begin
            for (int k = 0; k < 4; k++) begin
                sum = fieldSigned(a, 4 * k, 4) + fieldSigned(b, 4 * k, 4);
                res[4 * k +: 4] = 4'(clampSigned(sum, 4));
            end
        end
        4'h8, 4'h9: begin
            b = {{12{rt[3]}}, rt};   // Signed word offset
            res = {a[15:1], 1'b0} + {b[14:0], 1'b0};
            writes = 1'b0;
            expIsAddr = 1'b1;
        end
        4'hA: res = {regMirror[rd][15:8], rs, rt};
        4'hB: res = {rs, rt, regMirror[rd][7:0]};
        default: writes = 1'b0;   // No-op gives zero
    endcase
    if (setsFlags) begin
        flagMirror[2] = (res == 16'h0000);
        flagMirror[1] = ovfl;
        flagMirror[0] = (op <= 4'h1) && res[15];   // N only for ADD and SUB
    end
    if (writes && (rd != 4'h0))
        regMirror[rd] = res;
    expResult = res;
endtask

`endif

//--- testbench/aluSubsystemTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "aluSettings.svh"

module aluSubsystemTb;

    // One slot of expected output, two cycles after issue
    typedef struct packed {
        logic        valid;
        logic [15:0] result;
        logic [3:0]  dest;
        logic        isAddr;
        logic [2:0]  flags;
    } expectT;

    localparam int numRows    = 49;
    localparam int cycleLimit = 8 + numRows + 2 + 10;   // Reset, table, latency, margin

    // Row is {idle, random imm8, instruction word}
    localparam logic [17:0] stimTable [numRows] = '{
        {2'b00, 16'hA134},   // LLB r1
        {2'b00, 16'hB112},   // LHB r1, r1 = 1234
        {2'b00, 16'hA2FF},
        {2'b00, 16'hB27F},   // r2 = 7FFF
        {2'b00, 16'h0312},   // ADD right behind, bypass and clamp high
        {2'b00, 16'hA400},
        {2'b00, 16'hB480},   // r4 = 8000
        {2'b00, 16'h1524},   // SUB overflows positive
        {2'b00, 16'h1542},   // SUB overflows negative
        {2'b00, 16'h2711},   // XOR of equal operands clears V and N
        {2'b00, 16'h1611},   // Zero result
        {2'b00, 16'h0611},
        {2'b00, 16'h2712},
        {2'b10, 16'h0000},
        {2'b00, 16'h4814},   // SLL 4
        {2'b00, 16'h5843},   // SRA 3 of 8000
        {2'b00, 16'h681C},   // ROR 12
        {2'b00, 16'h4920},   // SLL 0
        {2'b00, 16'h595F},   // SRA 15
        {2'b00, 16'h6910},   // ROR 0
        {2'b00, 16'h0922},   // Overflow sets V ahead of RED
        {2'b00, 16'h3A12},   // RED
        {2'b00, 16'h7A21},   // PADDSB mixed lanes
        {2'b00, 16'hAB77},
        {2'b00, 16'hBB77},   // r11 = 7777
        {2'b00, 16'h7BBB},   // Every lane clamps to 7
        {2'b00, 16'h7C44},   // Only the top lane clamps to 8
        {2'b10, 16'h0000},
        {2'b10, 16'h0000},
        {2'b00, 16'h8315},   // LW, r3 kept
        {2'b00, 16'h932E},   // SW, negative offset
        {2'b00, 16'h0D30},   // Read r3 back
        {2'b00, 16'hA055},   // r0 write dropped
        {2'b00, 16'h0D01},
        {2'b00, 16'hC123},
        {2'b00, 16'hDAB4},
        {2'b00, 16'hE789},
        {2'b00, 16'hF0AB},
        {2'b00, 16'h0EA0},   // r10 after no-ops
        {2'b00, 16'h0E70},   // r7 after no-ops
        {2'b01, 16'hAE00},   // Random LLB
        {2'b01, 16'hBE00},   // Random LHB
        {2'b00, 16'h0FE1},
        {2'b10, 16'h0000},
        {2'b00, 16'h3FE2},
        {2'b00, 16'h5FE7},
        {2'b00, 16'h2FEE},
        {2'b01, 16'hAF00},
        {2'b00, 16'h1FF1}
    };

    logic                   clk;
    logic                   rst;
    logic                   instrValid;
    isaPkg::instrT          instr;
    logic                   resultValid;
    logic [`DATA_WIDTH-1:0] result;
    isaPkg::regAddrT        resultDest;
    logic                   isAddress;
    execPkg::flagsT         flags;

    expectT      expQ [$];   // In-flight expectations
    logic [31:0] lfsrState;
    int          cycleCount = 0;

    `include "aluRefModel.svh"

    aluSubsystem aluSubsystem_inst (
        .clk         (clk),
        .rst         (rst),
        .instrValid  (instrValid),
        .instr       (instr),
        .resultValid (resultValid),
        .result      (result),
        .resultDest  (resultDest),
        .isAddress   (isAddress),
        .flags       (flags)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois LFSR, one step per bit
    task automatic randomByte(output logic [7:0] bits);
        bits = '0;
        for (int k = 0; k < 8; k++) begin
            bits = {bits[6:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
        end
    endtask

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: time %0t, %s is %h, expected %h", $time, name, actual, expected);
            $display("test failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic checkOutputs(input expectT exp);
        compareValue("resultValid", 32'(resultValid), 32'(exp.valid));
        if (exp.valid) begin   // Payload holds stale data when idle
            compareValue("result", 32'(result), 32'(exp.result));
            compareValue("resultDest", 32'(resultDest), 32'(exp.dest));
            compareValue("isAddress", 32'(isAddress), 32'(exp.isAddr));
        end
        compareValue("flags", 32'(flags), 32'(exp.flags));
    endtask

    // Watchdog
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("test failed");
            $fatal(1, "watchdog expired");
        end
    end

    initial begin
        expectT      slot;
        logic [17:0] row;
        logic [15:0] word;
        logic [7:0]  rb;
        logic [15:0] expResult;
        logic        expIsAddr;
        rst = 1'b1;
        instrValid = 1'b0;
        instr = '0;
        lfsrState = 32'ha150;
        modelReset();
        repeat (8) @(posedge clk);
        #5;
        rst = 1'b0;
        slot = '0;
        expQ.push_back(slot);   // Two idle cycles already in the pipe
        expQ.push_back(slot);
        for (int i = 0; i < numRows + 2; i++) begin
            @(posedge clk);
            #5;
            checkOutputs(expQ.pop_front());
            row = (i < numRows) ? stimTable[i] : {2'b10, 16'h0000};   // Drain with idles
            slot = '0;
            if (row[17]) begin
                instrValid = 1'b0;
                instr = '0;
            end else begin
                word = row[15:0];
                if (row[16]) begin
                    randomByte(rb);
                    word[7:0] = rb;
                end
                modelIssue(word, expResult, expIsAddr);
                slot.valid = 1'b1;
                slot.result = expResult;
                slot.dest = word[11:8];
                slot.isAddr = expIsAddr;
                instrValid = 1'b1;
                instr = isaPkg::instrT'(word);
            end
            slot.flags = flagMirror;   // Flags after this issue
            expQ.push_back(slot);
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+source
+incdir+testbench
source/isaPkg.sv
source/execPkg.sv
source/execBus.sv
source/pipeStage.sv
source/aluCore.sv
source/operandDecode.sv
source/executeUnit.sv
source/aluSubsystem.sv
testbench/aluSubsystemTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator; exit status is the verdict

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f --top-module aluSubsystemTb -o simv
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build returned status $status"
    exit $status
fi

./obj_dir/simv
status=$?
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit $status
fi

exit 0
